// ==== all.f ====
+incdir+hdl
hdl/l1d_pkg.sv
hdl/l1d_victim_sel.sv
hdl/l1d_tag_store.sv
hdl/l1d_data_store.sv
hdl/l1d_ctrl_fsm.sv
hdl/l1d_cache_top.sv
dv/l1d_cache_props.sv
dv/l1d_cache_tb.sv

// ==== dv/l1d_cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l1d_defines.svh"

module l1d_cache_tb import l1d_pkg::*; ();

    localparam int RANDOM_REQS = 300;
    localparam int TOTAL_REQS  = 13 + RANDOM_REQS;
    localparam int BLOCKS      = 1 << (`L1D_ADDR_W - `L1D_OFFSET_W);
    localparam logic [`L1D_ADDR_W-1:0] ADDR_A = 16'h1050;
    localparam logic [`L1D_ADDR_W-1:0] ADDR_B = 16'h2054;
    localparam logic [`L1D_ADDR_W-1:0] ADDR_C = 16'h3058;

    logic                      clk_i;
    logic                      rstn_i;
    logic                      cpu_req_valid_i;
    cpu_req_t                  cpu_req_i;
    logic                      cpu_req_ready_o;
    logic                      cpu_resp_valid_o;
    logic [`L1D_WORD_W-1:0]    cpu_resp_data_o;
    logic                      cpu_resp_ready_i;
    logic                      mem_req_valid_o;
    mem_req_t                  mem_req_o;
    logic                      mem_req_ready_i;
    logic                      mem_resp_valid_i;
    logic [`L1D_BLOCK_W-1:0]   mem_resp_data_i;
    logic                      mem_resp_ready_o;

    logic [`L1D_BLOCK_W-1:0]   mem_blocks [BLOCKS];
    logic [`L1D_WORD_W-1:0]    shadow_mem [int];
    logic [`L1D_WORD_W-1:0]    exp_q [$];
    string                     name_q [$];
    int                        error_count = 0;
    int                        issued = 0;
    int                        mem_req_count = 0;
    int                        wb_count = 0;
    logic [`L1D_ADDR_W-1:0]    last_wb_addr;
    logic [`L1D_BLOCK_W-1:0]   last_wb_block;

    l1d_cache_top l1d_cache_top_i (.*);

    bind l1d_cache_top l1d_cache_props l1d_cache_props_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic logic [`L1D_WORD_W-1:0] init_word(input int word_addr);
        return `L1D_WORD_W'(word_addr) ^ 32'hA5A5_0000;
    endfunction

    // Last value written to the word, else the memory's initial pattern
    function automatic logic [`L1D_WORD_W-1:0] expected_read(input logic [`L1D_ADDR_W-1:0] addr);
        int wa;
        wa = int'(addr[`L1D_ADDR_W-1:2]);
        if (shadow_mem.exists(wa)) begin
            return shadow_mem[wa];
        end
        return init_word(wa);
    endfunction

    function automatic logic [`L1D_WORD_W-1:0] word_of(input logic [`L1D_BLOCK_W-1:0] blk,
                                                       input logic [`L1D_ADDR_W-1:0] addr);
        return blk[addr[`L1D_OFFSET_W-1:2]*`L1D_WORD_W +: `L1D_WORD_W];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    // One request, then wait for its response; optional response back-pressure
    task automatic cpu_access(input string name, input mem_op_e op,
                              input logic [`L1D_ADDR_W-1:0] addr,
                              input logic [`L1D_WORD_W-1:0] wdata,
                              input bit stall, output int latency);
        cpu_req_t req;
        int       hold;
        bit       done;
        req.addr  = addr;
        req.wdata = wdata;
        req.op    = op;
        hold      = stall ? $urandom_range(1, 4) : 0;
        cpu_req_valid_i  <= 1'b1;
        cpu_req_i        <= req;
        cpu_resp_ready_i <= !stall;
        do begin
            @(posedge clk_i);
        end while (cpu_req_ready_o !== 1'b1);
        if (op == WRITE) begin
            shadow_mem[int'(addr[`L1D_ADDR_W-1:2])] = wdata;
            exp_q.push_back(wdata);
        end else begin
            exp_q.push_back(expected_read(addr));
        end
        name_q.push_back(name);
        issued++;
        cpu_req_valid_i <= 1'b0;
        latency = 0;
        done    = 1'b0;
        while (!done) begin
            @(posedge clk_i);
            latency++;
            if (cpu_resp_valid_o && cpu_resp_ready_i) begin
                done = 1'b1;
            end else if (cpu_resp_valid_o) begin
                hold--;
                if (hold <= 0) begin
                    cpu_resp_ready_i <= 1'b1;
                end
            end
        end
    endtask

    always @(posedge clk_i) begin : response_checker
        if (rstn_i === 1'b1 && cpu_resp_valid_o === 1'b1 && cpu_resp_ready_i === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: cache sent a response with no request outstanding");
                error_count++;
            end else begin
                check_value(name_q.pop_front(), exp_q.pop_front(), cpu_resp_data_o);
            end
        end
    end

    // Block memory with random accept and read latency
    initial begin : memory_model
        mem_req_t req;
        mem_req_ready_i  <= 1'b0;
        mem_resp_valid_i <= 1'b0;
        mem_resp_data_i  <= '0;
        for (int b = 0; b < BLOCKS; b++) begin
            for (int w = 0; w < `L1D_BLOCK_W / `L1D_WORD_W; w++) begin
                mem_blocks[b][w*`L1D_WORD_W +: `L1D_WORD_W] = init_word(b * 4 + w);
            end
        end
        forever begin
            @(posedge clk_i);
            if (rstn_i === 1'b1 && mem_req_valid_o === 1'b1) begin
                repeat ($urandom_range(0, 3)) @(posedge clk_i);
                mem_req_ready_i <= 1'b1;
                @(posedge clk_i);
                req = mem_req_o;
                mem_req_ready_i <= 1'b0;
                mem_req_count++;
                if (req.op == WRITE) begin
                    mem_blocks[req.addr[`L1D_ADDR_W-1:`L1D_OFFSET_W]] = req.wdata;
                    last_wb_addr  = req.addr;
                    last_wb_block = req.wdata;
                    wb_count++;
                end else begin
                    repeat ($urandom_range(2, 5) - 1) @(posedge clk_i);
                    mem_resp_valid_i <= 1'b1;
                    mem_resp_data_i  <= mem_blocks[req.addr[`L1D_ADDR_W-1:`L1D_OFFSET_W]];
                    do begin
                        @(posedge clk_i);
                    end while (mem_resp_ready_o !== 1'b1);
                    mem_resp_valid_i <= 1'b0;
                    mem_resp_data_i  <= '0;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (200 * TOTAL_REQS + 10) @(posedge clk_i);
        $display("ERROR: watchdog expired, the cache stopped answering requests");
        $display("Test FAILED");
        $finish;
    end

    initial begin : stimulus
        int                      lat;
        int                      reqs_before;
        int                      wb_before;
        int                      fails;
        logic [`L1D_ADDR_W-1:0]  addr;
        mem_op_e                 op;
        void'($urandom(56282));
        rstn_i           <= 1'b0;
        cpu_req_valid_i  <= 1'b0;
        cpu_req_i        <= '0;
        cpu_resp_ready_i <= 1'b1;
        repeat (2) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(posedge clk_i);

        check_value("reset_req_ready", 32'd1, 32'(cpu_req_ready_o));
        check_value("reset_resp_valid", 32'd0, 32'(cpu_resp_valid_o));
        check_value("reset_mem_req_valid", 32'd0, 32'(mem_req_valid_o));
        check_value("reset_mem_resp_ready", 32'd0, 32'(mem_resp_ready_o));

        cpu_access("read_miss", READ, 16'h0100, '0, 1'b0, lat);
        reqs_before = mem_req_count;
        cpu_access("read_hit", READ, 16'h0100, '0, 1'b0, lat);
        check_value("read_hit_latency", 32'd2, 32'(lat));
        check_value("read_hit_mem_reqs", 32'(reqs_before), 32'(mem_req_count));

        cpu_access("write_word", WRITE, 16'h0204, 32'hDEAD_BEEF, 1'b0, lat);
        cpu_access("write_readback", READ, 16'h0204, '0, 1'b0, lat);
        cpu_access("write_neighbour", READ, 16'h0200, '0, 1'b0, lat);
        cpu_access("write_neighbour", READ, 16'h0208, '0, 1'b0, lat);
        cpu_access("write_neighbour", READ, 16'h020C, '0, 1'b0, lat);

        // Three tags in set 5, so the third write must evict a dirty line
        cpu_access("evict_write_a", WRITE, ADDR_A, 32'h1111_AAAA, 1'b0, lat);
        cpu_access("evict_write_b", WRITE, ADDR_B, 32'h2222_BBBB, 1'b0, lat);
        wb_before = wb_count;
        cpu_access("evict_write_c", WRITE, ADDR_C, 32'h3333_CCCC, 1'b0, lat);
        check_value("evict_wb_count", 32'(wb_before + 1), 32'(wb_count));
        if (last_wb_addr == {ADDR_A[`L1D_ADDR_W-1:`L1D_OFFSET_W], 4'h0}) begin
            check_value("evict_wb_word", expected_read(ADDR_A), word_of(last_wb_block, ADDR_A));
        end else if (last_wb_addr == {ADDR_B[`L1D_ADDR_W-1:`L1D_OFFSET_W], 4'h0}) begin
            check_value("evict_wb_word", expected_read(ADDR_B), word_of(last_wb_block, ADDR_B));
        end else begin
            $display("ERROR: write-back went to block %h, which holds no dirty line", last_wb_addr);
            error_count++;
        end
        cpu_access("evict_read_a", READ, ADDR_A, '0, 1'b0, lat);
        cpu_access("evict_read_b", READ, ADDR_B, '0, 1'b0, lat);
        cpu_access("evict_read_c", READ, ADDR_C, '0, 1'b0, lat);

        for (int i = 0; i < RANDOM_REQS; i++) begin
            addr = {7'b0, 7'($urandom_range(0, 127)), 2'b00};
            op   = ($urandom_range(0, 1) == 1) ? WRITE : READ;
            cpu_access("random_mix", op, addr, $urandom, $urandom_range(0, 2) == 0, lat);
        end

        repeat (3) @(posedge clk_i);
        if (exp_q.size() != 0) begin
            $display("ERROR: %0d responses never arrived", exp_q.size());
            error_count++;
        end
        fails = int'(l1d_cache_top_i.l1d_cache_props_i.assert_fails);
        $display("Done: %0d requests, %0d check errors, %0d assertion failures",
                 issued, error_count, fails);
        if (error_count == 0 && fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/l1d_cache_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l1d_defines.svh"

module l1d_cache_props import l1d_pkg::*; (
    input  wire                        clk_i,
    input  wire                        rstn_i,
    input  wire                        cpu_req_valid_i,
    input  wire cpu_req_t              cpu_req_i,
    input  wire                        cpu_req_ready_o,
    input  wire                        cpu_resp_valid_o,
    input  wire  [`L1D_WORD_W-1:0]     cpu_resp_data_o,
    input  wire                        cpu_resp_ready_i,
    input  wire                        mem_req_valid_o,
    input  wire mem_req_t              mem_req_o,
    input  wire                        mem_req_ready_i,
    input  wire                        mem_resp_valid_i,
    input  wire  [`L1D_BLOCK_W-1:0]    mem_resp_data_i,
    input  wire                        mem_resp_ready_o
);

    int unsigned assert_fails = 0;
    logic        pending_q;

    // Request accepted and its response not yet taken
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            pending_q <= 1'b0;
        end else if (cpu_req_valid_i && cpu_req_ready_o) begin
            pending_q <= 1'b1;
        end else if (cpu_resp_valid_o && cpu_resp_ready_i) begin
            pending_q <= 1'b0;
        end
    end

    cpu_req_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cpu_req_valid_i && !cpu_req_ready_o |=> cpu_req_valid_i && $stable(cpu_req_i))
        else begin
            assert_fails++;
            $error("cpu request dropped or changed while the cache was not ready");
        end

    cpu_resp_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cpu_resp_valid_o && !cpu_resp_ready_i |=> cpu_resp_valid_o && $stable(cpu_resp_data_o))
        else begin
            assert_fails++;
            $error("cpu response dropped or changed under back-pressure");
        end

    mem_req_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o))
        else begin
            assert_fails++;
            $error("memory request dropped or changed while memory was not ready");
        end

    mem_resp_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_resp_valid_i && !mem_resp_ready_o |=> mem_resp_valid_i && $stable(mem_resp_data_i))
        else begin
            assert_fails++;
            $error("memory response dropped or changed before the cache took it");
        end

    // One request in flight, so no accept until its response is taken
    no_accept_pending: assert property (@(posedge clk_i) disable iff (!rstn_i)
        pending_q |-> !cpu_req_ready_o)
        else begin
            assert_fails++;
            $error("cache ready for a new request while a response is pending");
        end

    wb_aligned: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_req_valid_o && mem_req_o.op == WRITE |-> mem_req_o.addr[`L1D_OFFSET_W-1:0] == '0)
        else begin
            assert_fails++;
            $error("write-back address is not block aligned");
        end

endmodule

`default_nettype wire

// ==== hdl/l1d_cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l1d_defines.svh"

module l1d_cache_top import l1d_pkg::*; (
    input  wire                        clk_i,
    input  wire                        rstn_i,

    input  wire                        cpu_req_valid_i,
    input  wire cpu_req_t              cpu_req_i,
    output logic                       cpu_req_ready_o,
    output logic                       cpu_resp_valid_o,
    output logic [`L1D_WORD_W-1:0]     cpu_resp_data_o,
    input  wire                        cpu_resp_ready_i,

    output logic                       mem_req_valid_o,
    output mem_req_t                   mem_req_o,
    input  wire                        mem_req_ready_i,
    input  wire                        mem_resp_valid_i,
    input  wire  [`L1D_BLOCK_W-1:0]    mem_resp_data_i,
    output logic                       mem_resp_ready_o
);

    lookup_t                   lookup;
    way_idx_t                  victim_way;
    way_idx_t                  way;
    logic [`L1D_BLOCK_W-1:0]   blk_rdata;
    logic [`L1D_WORD_W-1:0]    word_rdata;
    logic [`L1D_INDEX_W-1:0]   index;
    logic [`L1D_TAG_W-1:0]     tag;
    logic                      fill_we;
    logic                      word_we;
    logic [`L1D_BLOCK_W-1:0]   fill_data;
    logic [`L1D_WORD_W-1:0]    word_wdata;
    logic [`L1D_OFFSET_W-3:0]  word_sel;
    logic                      advance;

    l1d_ctrl_fsm l1d_ctrl_fsm_i (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .cpu_req_valid_i  (cpu_req_valid_i),
        .cpu_req_i        (cpu_req_i),
        .cpu_req_ready_o  (cpu_req_ready_o),
        .cpu_resp_valid_o (cpu_resp_valid_o),
        .cpu_resp_data_o  (cpu_resp_data_o),
        .cpu_resp_ready_i (cpu_resp_ready_i),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_o        (mem_req_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_data_i  (mem_resp_data_i),
        .mem_resp_ready_o (mem_resp_ready_o),
        .lookup_i         (lookup),
        .victim_way_i     (victim_way),
        .blk_rdata_i      (blk_rdata),
        .word_rdata_i     (word_rdata),
        .index_o          (index),
        .way_o            (way),
        .tag_o            (tag),
        .fill_we_o        (fill_we),
        .word_we_o        (word_we),
        .fill_data_o      (fill_data),
        .word_wdata_o     (word_wdata),
        .word_sel_o       (word_sel),
        .advance_o        (advance)
    );

    l1d_tag_store l1d_tag_store_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .index_i   (index),
        .tag_i     (tag),
        .way_i     (way),
        .fill_we_i (fill_we),
        .word_we_i (word_we),
        .lookup_o  (lookup)
    );

    l1d_data_store l1d_data_store_i (
        .clk_i        (clk_i),
        .index_i      (index),
        .way_i        (way),
        .word_sel_i   (word_sel),
        .fill_we_i    (fill_we),
        .fill_data_i  (fill_data),
        .word_we_i    (word_we),
        .word_wdata_i (word_wdata),
        .blk_rdata_o  (blk_rdata),
        .word_rdata_o (word_rdata)
    );

    l1d_victim_sel l1d_victim_sel_i (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .valid_mask_i (lookup.valid),
        .advance_i    (advance),
        .victim_way_o (victim_way)
    );

endmodule

`default_nettype wire

// ==== hdl/l1d_ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l1d_defines.svh"

module l1d_ctrl_fsm import l1d_pkg::*; (
    input  wire                               clk_i,
    input  wire                               rstn_i,

    input  wire                               cpu_req_valid_i,
    input  wire cpu_req_t                     cpu_req_i,
    output logic                              cpu_req_ready_o,
    output logic                              cpu_resp_valid_o,
    output logic [`L1D_WORD_W-1:0]            cpu_resp_data_o,
    input  wire                               cpu_resp_ready_i,

    output logic                              mem_req_valid_o,
    output mem_req_t                          mem_req_o,
    input  wire                               mem_req_ready_i,
    input  wire                               mem_resp_valid_i,
    input  wire  [`L1D_BLOCK_W-1:0]           mem_resp_data_i,
    output logic                              mem_resp_ready_o,

    input  wire lookup_t                      lookup_i,
    input  wire way_idx_t                     victim_way_i,
    input  wire  [`L1D_BLOCK_W-1:0]           blk_rdata_i,
    input  wire  [`L1D_WORD_W-1:0]            word_rdata_i,

    output logic [`L1D_INDEX_W-1:0]           index_o,
    output way_idx_t                          way_o,
    output logic [`L1D_TAG_W-1:0]             tag_o,
    output logic                              fill_we_o,
    output logic                              word_we_o,
    output logic [`L1D_BLOCK_W-1:0]           fill_data_o,
    output logic [`L1D_WORD_W-1:0]            word_wdata_o,
    output logic [`L1D_OFFSET_W-3:0]          word_sel_o,
    output logic                              advance_o
);

    cache_state_e             state_q;
    cache_state_e             state_d;
    cpu_req_t                 req_q;
    logic [`L1D_WORD_W-1:0]   resp_data_q;
    way_idx_t                 victim_q;

    // Fields of the request in flight
    assign tag_o        = req_q.addr[`L1D_ADDR_W-1 -: `L1D_TAG_W];
    assign index_o      = req_q.addr[`L1D_OFFSET_W +: `L1D_INDEX_W];
    assign word_sel_o   = req_q.addr[2 +: `L1D_OFFSET_W-2];
    assign word_wdata_o = req_q.wdata;
    assign fill_data_o  = mem_resp_data_i;

    // Hit way during lookup, latched victim afterwards
    assign way_o = (state_q != LOOKUP) ? victim_q :
                   (lookup_i.hit ? lookup_i.hit_way : victim_way_i);

    assign cpu_req_ready_o  = (state_q == IDLE);
    assign cpu_resp_valid_o = (state_q == RESPOND);
    assign cpu_resp_data_o  = resp_data_q;
    assign mem_req_valid_o  = (state_q == WB_REQ) || (state_q == FILL_REQ);
    assign mem_resp_ready_o = (state_q == FILL_WAIT);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cpu_req_valid_i && cpu_req_ready_o) begin
            req_q <= cpu_req_i;
        end
        if (state_q == LOOKUP && lookup_i.hit) begin
            // A write answers with the value written
            resp_data_q <= (req_q.op == WRITE) ? req_q.wdata : word_rdata_i;
        end
        if (state_q == LOOKUP && !lookup_i.hit) begin
            victim_q <= victim_way_i;
        end
    end

    always_comb begin
        state_d   = state_q;
        word_we_o = 1'b0;
        fill_we_o = 1'b0;
        advance_o = 1'b0;
        case (state_q)
            IDLE: begin
                if (cpu_req_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (lookup_i.hit) begin
                    word_we_o = (req_q.op == WRITE);
                    state_d   = RESPOND;
                end else begin
                    advance_o = 1'b1;
                    if (lookup_i.valid[victim_way_i] && lookup_i.dirty[victim_way_i]) begin
                        state_d = WB_REQ;
                    end else begin
                        state_d = FILL_REQ;
                    end
                end
            end
            RESPOND: begin
                if (cpu_resp_ready_i) begin
                    state_d = IDLE;
                end
            end
            WB_REQ: begin
                if (mem_req_ready_i) begin
                    state_d = FILL_REQ;
                end
            end
            FILL_REQ: begin
                if (mem_req_ready_i) begin
                    state_d = FILL_WAIT;
                end
            end
            FILL_WAIT: begin
                // Refilled line is then found by the normal hit path
                if (mem_resp_valid_i) begin
                    fill_we_o = 1'b1;
                    state_d   = LOOKUP;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_comb begin
        mem_req_o.op    = READ;
        mem_req_o.addr  = {tag_o, index_o, {`L1D_OFFSET_W{1'b0}}};
        mem_req_o.wdata = '0;
        if (state_q == WB_REQ) begin
            // Victim block goes back under its own tag
            mem_req_o.op    = WRITE;
            mem_req_o.addr  = {lookup_i.tags[victim_q], index_o, {`L1D_OFFSET_W{1'b0}}};
            mem_req_o.wdata = blk_rdata_i;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/l1d_data_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l1d_defines.svh"

module l1d_data_store import l1d_pkg::*; (
    input  wire                        clk_i,
    input  wire  [`L1D_INDEX_W-1:0]    index_i,
    input  wire way_idx_t              way_i,
    input  wire  [`L1D_OFFSET_W-3:0]   word_sel_i,
    input  wire                        fill_we_i,
    input  wire  [`L1D_BLOCK_W-1:0]    fill_data_i,
    input  wire                        word_we_i,
    input  wire  [`L1D_WORD_W-1:0]     word_wdata_i,
    output logic [`L1D_BLOCK_W-1:0]    blk_rdata_o,
    output logic [`L1D_WORD_W-1:0]     word_rdata_o
);

    logic [`L1D_BLOCK_W-1:0] blk_mem [`L1D_SETS][`L1D_WAYS];

    // Whole block on a fill, else a single word merge
    always_ff @(posedge clk_i) begin
        if (fill_we_i) begin
            blk_mem[index_i][way_i] <= fill_data_i;
        end else if (word_we_i) begin
            blk_mem[index_i][way_i][word_sel_i*`L1D_WORD_W +: `L1D_WORD_W] <= word_wdata_i;
        end
    end

    assign blk_rdata_o  = blk_mem[index_i][way_i];
    assign word_rdata_o = blk_rdata_o[word_sel_i*`L1D_WORD_W +: `L1D_WORD_W];

endmodule

`default_nettype wire

// ==== hdl/l1d_tag_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l1d_defines.svh"

module l1d_tag_store import l1d_pkg::*; (
    input  wire                        clk_i,
    input  wire                        rstn_i,
    input  wire  [`L1D_INDEX_W-1:0]    index_i,
    input  wire  [`L1D_TAG_W-1:0]      tag_i,
    input  wire way_idx_t              way_i,
    input  wire                        fill_we_i,
    input  wire                        word_we_i,
    output lookup_t                    lookup_o
);

    logic [`L1D_TAG_W-1:0] tag_mem [`L1D_SETS][`L1D_WAYS];
    logic [`L1D_WAYS-1:0]  valid_q [`L1D_SETS];
    logic [`L1D_WAYS-1:0]  dirty_q [`L1D_SETS];

    always_ff @(posedge clk_i) begin
        if (fill_we_i) begin
            tag_mem[index_i][way_i] <= tag_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int s = 0; s < `L1D_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (fill_we_i) begin
            // Freshly filled line is clean
            valid_q[index_i][way_i] <= 1'b1;
            dirty_q[index_i][way_i] <= 1'b0;
        end else if (word_we_i) begin
            dirty_q[index_i][way_i] <= 1'b1;
        end
    end

    // Compare against every way of the addressed set
    always_comb begin
        lookup_o       = '0;
        lookup_o.valid = valid_q[index_i];
        lookup_o.dirty = dirty_q[index_i];
        for (int w = 0; w < `L1D_WAYS; w++) begin
            lookup_o.tags[w] = tag_mem[index_i][w];
            if (valid_q[index_i][w] && tag_mem[index_i][w] == tag_i) begin
                lookup_o.hit     = 1'b1;
                lookup_o.hit_way = way_idx_t'(w);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/l1d_victim_sel.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "l1d_defines.svh"

module l1d_victim_sel import l1d_pkg::*; (
    input  wire                        clk_i,
    input  wire                        rstn_i,
    input  wire  [`L1D_WAYS-1:0]       valid_mask_i,
    input  wire                        advance_i,
    output way_idx_t                   victim_way_o
);

    way_idx_t rr_q;

    // Round-robin eviction counter, one step per fill
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rr_q <= '0;
        end else if (advance_i) begin
            rr_q <= (rr_q == way_idx_t'(`L1D_WAYS-1)) ? '0 : rr_q + 1'b1;
        end
    end

    // Lowest invalid way wins over the counter
    always_comb begin
        victim_way_o = rr_q;
        for (int w = `L1D_WAYS-1; w >= 0; w--) begin
            if (!valid_mask_i[w]) begin
                victim_way_o = way_idx_t'(w);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/l1d_pkg.sv ====
`default_nettype none

package l1d_pkg;

    `include "l1d_defines.svh"

    typedef enum logic {
        READ,
        WRITE
    } mem_op_e;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        RESPOND,
        WB_REQ,
        FILL_REQ,
        FILL_WAIT
    } cache_state_e;

    typedef logic [$clog2(`L1D_WAYS)-1:0] way_idx_t;

    typedef struct packed {
        logic [`L1D_ADDR_W-1:0] addr;
        logic [`L1D_WORD_W-1:0] wdata;
        mem_op_e                op;
    } cpu_req_t;

    // Address is always block aligned
    typedef struct packed {
        logic [`L1D_ADDR_W-1:0]  addr;
        logic [`L1D_BLOCK_W-1:0] wdata;
        mem_op_e                 op;
    } mem_req_t;

    typedef struct packed {
        logic                                  hit;
        way_idx_t                              hit_way;
        logic [`L1D_WAYS-1:0]                  valid;
        logic [`L1D_WAYS-1:0]                  dirty;
        logic [`L1D_WAYS-1:0][`L1D_TAG_W-1:0]  tags;
    } lookup_t;

endpackage

`default_nettype wire

// ==== hdl/l1d_defines.svh ====
`ifndef L1D_DEFINES_SVH
`define L1D_DEFINES_SVH

// Byte address and processor word
`define L1D_ADDR_W   16
`define L1D_WORD_W   32

// One block holds four words
`define L1D_BLOCK_W  128

// Cache geometry
`define L1D_WAYS     2
`define L1D_SETS     8

// Address split, top bit down: tag, index, offset
`define L1D_OFFSET_W 4
`define L1D_INDEX_W  3
`define L1D_TAG_W    9

`endif
